// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module uart_controller_tb -o sim_uart &&
./obj_dir/sim_uart ||
exit 1

// ==== source/baud_tick_gen.sv ====
module baud_tick_gen #(
    parameter int BAUD_DIV = 16  // Clock cycles per bit
) (
    input  logic clk,
    input  logic reset,
    output logic bit_tick,
    output logic mid_tick
);

    localparam int CNT_W = $clog2(BAUD_DIV);

    logic [CNT_W-1:0] baud_cnt;

    // Free-running, both ticks are registered pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            baud_cnt <= '0;
            bit_tick <= 1'b0;
            mid_tick <= 1'b0;
        end else begin
            if (baud_cnt == CNT_W'(BAUD_DIV - 1)) begin
                baud_cnt <= '0;  // Wrap at end of bit period
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            bit_tick <= (baud_cnt == CNT_W'(BAUD_DIV - 1));
            mid_tick <= (baud_cnt == CNT_W'(BAUD_DIV / 2 - 1));  // Half a bit after bit_tick
        end
    end

endmodule

// ==== source/rx_word_assembler.sv ====
module rx_word_assembler
    import uart_pkg::*;
#(
    parameter int TIMEOUT_BITS = 31  // Mid-bit ticks to wait for a second character
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        mid_tick,
    input  logic        start_seen,
    input  logic        char_valid,
    input  logic [7:0]  char,
    output uart_entry_t word,
    output logic        word_valid
);

    localparam int CNT_W = $clog2(TIMEOUT_BITS + 1);

    logic [7:0]       low_char;
    logic             have_low;    // First character held
    logic [CNT_W-1:0] idle_ticks;
    logic             timeout_hit;

    // A character or a new frame takes priority over the timeout
    assign timeout_hit = have_low && mid_tick && !char_valid && !start_seen &&
                         (idle_ticks == CNT_W'(TIMEOUT_BITS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            have_low   <= 1'b0;
            idle_ticks <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (char_valid) begin
                word_valid <= have_low;  // Second character completes the word
                have_low   <= !have_low;
                idle_ticks <= '0;
            end else if (start_seen) begin
                idle_ticks <= '0;        // Next character is on its way
            end else if (timeout_hit) begin
                word_valid <= 1'b1;
                have_low   <= 1'b0;
                idle_ticks <= '0;
            end else if (have_low && mid_tick) begin
                idle_ticks <= idle_ticks + 1'b1;
            end
        end
    end

    // Low byte first on the wire
    always_ff @(posedge clk) begin
        if (char_valid && !have_low) begin
            low_char <= char;
        end
        if (char_valid && have_low) begin
            word.data <= {char, low_char};
            word.flag <= 1'b0;
        end else if (timeout_hit) begin
            word.data <= {8'h00, low_char};  // Pad the missing high byte
            word.flag <= 1'b1;
        end
    end

endmodule

// ==== source/uart_controller.sv ====
module uart_controller
    import uart_pkg::*;
#(
    parameter int BAUD_DIV     = 16,  // Short bit period for simulation
    parameter int TIMEOUT_BITS = 31
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        device_select,
    input  reg_offset_t register_offset,
    input  logic        read_req,
    input  logic        write_req,
    input  logic [15:0] wdata,
    output logic [15:0] rdata,
    output logic        uart_tx,
    input  logic        uart_rx
);

    logic        bit_tick;
    logic        mid_tick;
    // TX path
    uart_entry_t tx_push;
    logic        tx_push_valid;
    uart_entry_t tx_entry;
    logic        tx_entry_valid;
    logic        tx_entry_ready;
    logic        tx_full;
    logic        tx_empty;
    logic        tx_busy;
    // RX path
    logic        char_valid;
    logic [7:0]  rx_char;
    logic        start_seen;
    uart_entry_t rx_word;
    logic        rx_word_valid;
    uart_entry_t rx_head;
    logic        rx_valid;
    logic        rx_pop;
    logic        rx_full;

    baud_tick_gen #(
        .BAUD_DIV(BAUD_DIV)
    ) baud_tick_gen_inst (
        .clk(clk), .reset(reset), .bit_tick(bit_tick), .mid_tick(mid_tick)
    );

    uart_regs uart_regs_inst (
        .clk(clk), .reset(reset), .device_select(device_select),
        .register_offset(register_offset), .read_req(read_req), .write_req(write_req),
        .wdata(wdata), .rdata(rdata), .tx_push(tx_push), .tx_push_valid(tx_push_valid),
        .tx_full(tx_full), .tx_empty(tx_empty), .tx_busy(tx_busy), .rx_head(rx_head),
        .rx_valid(rx_valid), .rx_pop(rx_pop), .rx_full(rx_full)
    );

    uart_fifo tx_fifo_inst (
        .clk(clk), .reset(reset), .in_entry(tx_push), .in_valid(tx_push_valid),
        .in_ready(), .out_entry(tx_entry), .out_valid(tx_entry_valid),
        .out_ready(tx_entry_ready), .full(tx_full), .empty(tx_empty)
    );

    uart_tx_serializer uart_tx_serializer_inst (
        .clk(clk), .reset(reset), .bit_tick(bit_tick), .entry(tx_entry),
        .entry_valid(tx_entry_valid), .entry_ready(tx_entry_ready), .busy(tx_busy),
        .uart_tx(uart_tx)
    );

    uart_rx_deframer uart_rx_deframer_inst (
        .clk(clk), .reset(reset), .mid_tick(mid_tick), .uart_rx(uart_rx),
        .char_valid(char_valid), .char(rx_char), .start_seen(start_seen)
    );

    rx_word_assembler #(
        .TIMEOUT_BITS(TIMEOUT_BITS)
    ) rx_word_assembler_inst (
        .clk(clk), .reset(reset), .mid_tick(mid_tick), .start_seen(start_seen),
        .char_valid(char_valid), .char(rx_char), .word(rx_word), .word_valid(rx_word_valid)
    );

    // No back-pressure to the wire, a word offered while full is lost
    uart_fifo rx_fifo_inst (
        .clk(clk), .reset(reset), .in_entry(rx_word), .in_valid(rx_word_valid),
        .in_ready(), .out_entry(rx_head), .out_valid(rx_valid),
        .out_ready(rx_pop), .full(rx_full), .empty()
    );

endmodule

// ==== source/uart_fifo.sv ====
module uart_fifo
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  uart_entry_t in_entry,
    input  logic        in_valid,
    output logic        in_ready,
    output uart_entry_t out_entry,
    output logic        out_valid,
    input  logic        out_ready,
    output logic        full,
    output logic        empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    uart_entry_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] head;   // Read pointer
    logic [PTR_W-1:0] tail;   // Write pointer
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign in_ready  = !full;      // Push while full is dropped
    assign out_valid = !empty;
    assign out_entry = mem[head];  // Head shown without a read cycle
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= in_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(FIFO_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(FIFO_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/uart_pkg.sv ====
package uart_pkg;

    // Register offsets on the CPU port
    typedef logic [3:0] reg_offset_t;

    localparam reg_offset_t REG_TX_DATA   = 4'h0;  // Word write, two characters
    localparam reg_offset_t REG_RX_DATA   = 4'h1;  // Read pops the RX queue
    localparam reg_offset_t REG_TX_STATUS = 4'h2;
    localparam reg_offset_t REG_RX_STATUS = 4'h3;
    localparam reg_offset_t REG_TX_BYTE   = 4'h4;  // Byte write, low byte only

    // Value seen on write-only and unmapped offsets
    localparam logic [15:0] UNMAPPED_READ = 16'hFFFF;

    localparam int FIFO_DEPTH = 8;  // Entries in each queue

    // Queue entry, flag is byte mode on TX and padded on RX
    typedef struct packed {
        logic [15:0] data;
        logic        flag;
    } uart_entry_t;

    typedef struct packed {
        logic [11:0] reserved;  // Reads zero
        logic        full;
        logic        empty;
        logic        busy;      // Serializer has an entry in flight
        logic        rsvd0;     // Reads zero
    } tx_status_t;

    typedef struct packed {
        logic [11:0] reserved;  // Reads zero
        logic        full;
        logic        empty;
        logic        available;
        logic        padded;    // Head word had no second character
    } rx_status_t;

endpackage

// ==== source/uart_regs.sv ====
module uart_regs
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        device_select,
    input  reg_offset_t register_offset,
    input  logic        read_req,
    input  logic        write_req,
    input  logic [15:0] wdata,
    output logic [15:0] rdata,
    output uart_entry_t tx_push,
    output logic        tx_push_valid,
    input  logic        tx_full,
    input  logic        tx_empty,
    input  logic        tx_busy,
    input  uart_entry_t rx_head,
    input  logic        rx_valid,
    output logic        rx_pop,
    input  logic        rx_full
);

    logic       write_now;
    logic       write_held;  // Write was already active last cycle
    logic       write_first;
    tx_status_t tx_status;
    rx_status_t rx_status;

    assign write_now   = device_select && write_req;
    assign write_first = write_now && !write_held;  // One push per write

    always_ff @(posedge clk) begin
        if (reset) begin
            write_held <= 1'b0;
        end else begin
            write_held <= write_now;
        end
    end

    // TX entry, flag marks byte mode
    assign tx_push.data  = wdata;
    assign tx_push.flag  = (register_offset == REG_TX_BYTE);
    assign tx_push_valid = write_first &&
                           (register_offset == REG_TX_DATA || register_offset == REG_TX_BYTE);

    // RX data read pops the queue head
    assign rx_pop = device_select && read_req && (register_offset == REG_RX_DATA);

    always_comb begin
        tx_status       = '0;
        tx_status.full  = tx_full;
        tx_status.empty = tx_empty;
        tx_status.busy  = tx_busy;

        rx_status           = '0;
        rx_status.full      = rx_full;
        rx_status.empty     = !rx_valid;
        rx_status.available = rx_valid;
        rx_status.padded    = rx_valid && rx_head.flag;  // Only for a real head
    end

    // Read mux, zero when no read is requested
    always_comb begin
        rdata = '0;
        if (device_select && read_req) begin
            case (register_offset)
                REG_RX_DATA:   rdata = rx_valid ? rx_head.data : '0;
                REG_TX_STATUS: rdata = tx_status;
                REG_RX_STATUS: rdata = rx_status;
                default:       rdata = UNMAPPED_READ;  // Data writes and holes
            endcase
        end
    end

endmodule

// ==== source/uart_rx_deframer.sv ====
module uart_rx_deframer (
    input  logic       clk,
    input  logic       reset,
    input  logic       mid_tick,
    input  logic       uart_rx,
    output logic       char_valid,
    output logic [7:0] char,
    output logic       start_seen
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,  // Falling edge seen, check start bit at mid_tick
        RX_DATA,   // Eight data bits, LSB first
        RX_STOP    // Stop bit, not checked
    } rx_state_t;

    rx_state_t  state;
    logic [2:0] rx_sync;  // Synchronizer chain
    logic       rx_prev;
    logic       rx_in;
    logic       rx_fall;
    logic [2:0] bit_idx;
    logic [7:0] char_sr;

    assign rx_in   = rx_sync[2];
    assign rx_fall = rx_prev && !rx_in;
    assign char    = char_sr;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= '1;  // Line idles high
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[1:0], uart_rx};
            rx_prev <= rx_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= RX_IDLE;
            bit_idx    <= '0;
            char_valid <= 1'b0;
            start_seen <= 1'b0;
        end else begin
            char_valid <= 1'b0;
            start_seen <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_fall) begin
                        start_seen <= 1'b1;
                        // A mid_tick on the edge itself is the start bit sample
                        state <= mid_tick ? RX_DATA : RX_START;
                    end
                end
                RX_START: begin
                    if (mid_tick) begin
                        state <= rx_in ? RX_IDLE : RX_DATA;  // High means a glitch
                    end
                end
                RX_DATA: begin
                    if (mid_tick) begin
                        bit_idx <= bit_idx + 1'b1;  // Wraps to zero after bit 7
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (mid_tick) begin
                        char_valid <= 1'b1;
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && mid_tick) begin
            char_sr <= {rx_in, char_sr[7:1]};
        end
    end

endmodule

// ==== source/uart_tx_serializer.sv ====
module uart_tx_serializer
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bit_tick,
    input  uart_entry_t entry,
    input  logic        entry_valid,
    output logic        entry_ready,
    output logic        busy,
    output logic        uart_tx
);

    typedef enum logic [1:0] {
        TX_IDLE,   // Line high, waiting for an entry
        TX_SHIFT,  // Sending bits on each bit_tick
        TX_DONE    // Release the entry from the queue
    } tx_state_t;

    tx_state_t   state;
    logic [19:0] frame_sr;   // Two frames, low byte frame in bits 9:0
    logic [4:0]  bits_left;  // Bits still to drive

    // Entry stays at the queue head until the last stop bit is done
    assign entry_ready = (state == TX_DONE);
    assign busy        = (state == TX_SHIFT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= TX_IDLE;
            bits_left <= '0;
            uart_tx   <= 1'b1;  // Idle high
        end else begin
            case (state)
                TX_IDLE: begin
                    if (entry_valid) begin
                        // Byte mode sends only the low frame
                        bits_left <= entry.flag ? 5'd10 : 5'd20;
                        state     <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (bit_tick) begin
                        if (bits_left == '0) begin
                            state <= TX_DONE;  // Stop bit has lasted a full period
                        end else begin
                            uart_tx   <= frame_sr[0];  // LSB first
                            bits_left <= bits_left - 1'b1;
                        end
                    end
                end
                TX_DONE: state <= TX_IDLE;  // Queue pops in this cycle
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Frame data: start 0, byte LSB first, stop 1, for both bytes
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && entry_valid) begin
            frame_sr <= {1'b1, entry.data[15:8], 1'b0, 1'b1, entry.data[7:0], 1'b0};
        end else if (state == TX_SHIFT && bit_tick) begin
            frame_sr <= {1'b1, frame_sr[19:1]};
        end
    end

endmodule

// ==== tb.f ====
source/uart_pkg.sv
source/baud_tick_gen.sv
source/uart_fifo.sv
source/uart_tx_serializer.sv
source/uart_rx_deframer.sv
source/rx_word_assembler.sv
source/uart_regs.sv
source/uart_controller.sv
tests/uart_controller_tb.sv

// ==== tests/uart_controller_tb.sv ====
module uart_controller_tb
    import uart_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BAUD_DIV     = 16;
    localparam int TIMEOUT_BITS = 31;
    localparam int POLL_LIMIT   = (20 + TIMEOUT_BITS + 10) * BAUD_DIV;

    logic        clk;
    logic        reset;
    logic        device_select;
    reg_offset_t register_offset;
    logic        read_req;
    logic        write_req;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic        uart_tx;
    logic        uart_rx;
    logic        loopback;  // TX pin wired back to RX pin
    logic        rx_drive;  // Line driven by the testbench when loopback is off

    logic [7:0]  op_q  [$];
    logic [15:0] dat_q [$];
    logic [15:0] exp_q [$];
    logic [31:0] lcg_state;

    assign uart_rx = loopback ? uart_tx : rx_drive;

    uart_controller #(
        .BAUD_DIV(BAUD_DIV),
        .TIMEOUT_BITS(TIMEOUT_BITS)
    ) uart_controller_inst (
        .clk(clk), .reset(reset), .device_select(device_select),
        .register_offset(register_offset), .read_req(read_req), .write_req(write_req),
        .wdata(wdata), .rdata(rdata), .uart_tx(uart_tx), .uart_rx(uart_rx)
    );

    always #4 clk = ~clk;  // 8 ns period

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Wire level of bit idx in a two frame word, low byte frame first
    function automatic logic frame_bit(logic [15:0] word, int idx);
        int         pos;
        logic [7:0] ch;
        pos = idx % 10;
        ch  = (idx < 10) ? word[7:0] : word[15:8];
        if (pos == 0) return 1'b0;  // Start bit
        if (pos == 9) return 1'b1;  // Stop bit
        return ch[pos - 1];         // Data LSB first
    endfunction

    task automatic check_status(tx_status_t exp_tx, tx_status_t got_tx,
                                rx_status_t exp_rx, rx_status_t got_rx);
        if (got_tx !== exp_tx) begin
            $display("FAIL tx_status expected %h got %h", exp_tx, got_tx);
            $display("Simulation failed");
            $fatal(1);
        end
        if (got_rx !== exp_rx) begin
            $display("FAIL rx_status expected %h got %h", exp_rx, got_rx);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_data(logic [15:0] expected, logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL rdata expected %h got %h", expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_line(logic expected, logic actual, int bit_idx);
        if (actual !== expected) begin
            $display("FAIL uart_tx bit %0d expected %h got %h", bit_idx, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic give_up(string what);
        $display("Timed out waiting for %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // One cycle strobe then an idle cycle before the next access
    task automatic bus_write(reg_offset_t off, logic [15:0] data);
        @(negedge clk);
        device_select   = 1'b1;
        write_req       = 1'b1;
        register_offset = off;
        wdata           = data;
        @(negedge clk);
        device_select = 1'b0;
        write_req     = 1'b0;
    endtask

    task automatic bus_read(reg_offset_t off, output logic [15:0] data);
        @(negedge clk);
        device_select   = 1'b1;
        read_req        = 1'b1;
        register_offset = off;
        #2 data = rdata;  // Combinational rdata has settled mid low phase
        @(negedge clk);
        device_select = 1'b0;
        read_req      = 1'b0;
    endtask

    task automatic read_status(output tx_status_t t, output rx_status_t r);
        logic [15:0] v;
        bus_read(REG_TX_STATUS, v);
        t = tx_status_t'(v);
        bus_read(REG_RX_STATUS, v);
        r = rx_status_t'(v);
    endtask

    task automatic wait_rx_available();
        logic [15:0] v;
        rx_status_t  r;
        int          polls;
        polls = 0;
        r     = '0;
        while (!r.available) begin
            if (polls == POLL_LIMIT) give_up("RX data");
            bus_read(REG_RX_STATUS, v);
            r = rx_status_t'(v);
            polls++;
        end
    endtask

    task automatic wait_tx_idle();
        logic [15:0] v;
        tx_status_t  t;
        int          polls;
        polls = 0;
        bus_read(REG_TX_STATUS, v);
        t = tx_status_t'(v);
        while (!t.empty || t.busy) begin
            if (polls == POLL_LIMIT) give_up("TX queue to drain");
            bus_read(REG_TX_STATUS, v);
            t = tx_status_t'(v);
            polls++;
        end
    endtask

    // Frame driven onto the RX pin with one bit per BAUD_DIV cycles
    task automatic send_raw_frame(logic [7:0] ch);
        logic [9:0] bits;
        bits = {1'b1, ch, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_drive = bits[i];
            repeat (BAUD_DIV - 1) @(negedge clk);
        end
    endtask

    // Poll then check status and the word at the RX head
    task automatic receive_and_check(logic [15:0] expected, logic padded);
        tx_status_t t;
        rx_status_t r;
        tx_status_t exp_t;
        rx_status_t exp_r;
        logic [15:0] v;
        wait_rx_available();
        wait_tx_idle();
        read_status(t, r);
        exp_t           = '0;
        exp_t.empty     = 1'b1;
        exp_r           = '0;
        exp_r.available = 1'b1;
        exp_r.padded    = padded;
        check_status(exp_t, t, exp_r, r);
        bus_read(REG_RX_DATA, v);
        check_data(expected, v);
    endtask

    task automatic check_frames(logic [15:0] word);
        int waits;
        loopback = 1'b0;
        bus_write(REG_TX_DATA, word);
        waits = 0;
        while (uart_tx) begin
            if (waits == 4 * BAUD_DIV) give_up("a start bit on uart_tx");
            @(negedge clk);
            waits++;
        end
        repeat (BAUD_DIV / 2 - 1) @(negedge clk);  // Middle of the start bit
        for (int i = 0; i < 20; i++) begin
            check_line(frame_bit(word, i), uart_tx, i);
            if (i < 19) repeat (BAUD_DIV) @(negedge clk);
        end
        wait_tx_idle();
    endtask

    task automatic run_burst(int expect_count);
        logic [15:0] words [9];
        tx_status_t  t;
        rx_status_t  r;
        tx_status_t  exp_t;
        rx_status_t  exp_r;
        logic [15:0] v;
        loopback = 1'b1;
        for (int i = 0; i < 9; i++) begin
            lcg_state = lcg_next(lcg_state);
            words[i]  = lcg_state[30:15];
        end
        for (int i = 0; i < 8; i++) bus_write(REG_TX_DATA, words[i]);
        read_status(t, r);
        exp_t       = '0;
        exp_t.full  = 1'b1;
        exp_t.busy  = 1'b1;
        exp_r       = '0;
        exp_r.empty = 1'b1;
        check_status(exp_t, t, exp_r, r);
        bus_write(REG_TX_DATA, words[8]);  // Dropped by the full queue
        for (int i = 0; i < expect_count; i++) begin
            wait_rx_available();
            bus_read(REG_RX_DATA, v);
            check_data(words[i], v);
        end
        wait_tx_idle();
        repeat (4 * BAUD_DIV) @(negedge clk);  // A ninth word would land here
        read_status(t, r);
        exp_t       = '0;
        exp_t.empty = 1'b1;
        check_status(exp_t, t, exp_r, r);
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] d;
        logic [15:0] e;
        fd = $fopen("tests/uart_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            $display("Simulation failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != 8'h23) begin
                if ($sscanf(line, "%h %h %h", op, d, e) == 3) begin
                    op_q.push_back(op);
                    dat_q.push_back(d);
                    exp_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        longint     limit_ns;
        logic [15:0] v;
        tx_status_t t;
        rx_status_t r;
        clk             = 1'b0;
        reset           = 1'b1;
        device_select   = 1'b0;
        register_offset = '0;
        read_req        = 1'b0;
        write_req       = 1'b0;
        wdata           = '0;
        loopback        = 1'b0;
        rx_drive        = 1'b1;
        lcg_state       = 32'd42;
        load_patterns();
        limit_ns = longint'(op_q.size()) * (20 + TIMEOUT_BITS + 10) * BAUD_DIV * 8 * 2;
        fork
            begin
                #(limit_ns);
                $display("Watchdog expired before the tests finished");
                $display("Simulation failed");
                $fatal(1);
            end
        join_none
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_line(1'b1, uart_tx, -1);  // Idle line after reset
        foreach (op_q[i]) begin
            case (op_q[i])
                8'h1: begin
                    loopback = 1'b1;
                    bus_write(REG_TX_DATA, dat_q[i]);
                    receive_and_check(exp_q[i], 1'b0);
                end
                8'h2: begin
                    loopback = 1'b1;
                    bus_write(REG_TX_BYTE, dat_q[i]);
                    receive_and_check(exp_q[i], 1'b1);
                end
                8'h3: run_burst(int'(exp_q[i]));
                8'h4: begin
                    loopback = 1'b0;
                    send_raw_frame(dat_q[i][7:0]);
                    receive_and_check(exp_q[i], 1'b1);
                end
                8'h5: begin
                    bus_read(reg_offset_t'(dat_q[i][3:0]), v);
                    check_data(exp_q[i], v);
                end
                8'h6: begin
                    read_status(t, r);
                    check_status(tx_status_t'(dat_q[i]), t, rx_status_t'(exp_q[i]), r);
                end
                8'h7: check_frames(dat_q[i]);
                default: begin
                    $display("Unknown operation code in the pattern file");
                    $display("Simulation failed");
                    $fatal(1);
                end
            endcase
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== tests/uart_patterns.txt ====
# op data expected, all hex
# op 1 word loopback, 2 byte write, 3 burst of nine (expected = words read), 4 raw rx frame
# op 5 read offset, 6 status (data = tx status, expected = rx status), 7 tx frame check
6 0004 0004
5 0000 ffff
5 0004 ffff
5 0007 ffff
5 0001 0000
7 a55a a55a
7 0f31 0f31
6 0004 0004
1 1234 1234
1 beef beef
1 00ff 00ff
6 0004 0004
2 7741 0041
2 00c3 00c3
4 005a 005a
4 00a7 00a7
1 8001 8001
3 0000 0008
6 0004 0004
5 0001 0000
5 0002 0004
